// File: include/soc_periph_defines.svh
`ifndef SOC_PERIPH_DEFINES_SVH
`define SOC_PERIPH_DEFINES_SVH

// number of timer slots on the bus
`define N_TIMERS        4

// peripheral bus widths
`define APB_ADDR_W      12
`define APB_DATA_W      32

// widths of the event vector and the timer counters
`define FC_EVT_W        32
`define TIMER_CNT_W     32

// address bits holding the slot number
`define SLOT_LSB        8
`define SLOT_MSB        11
`define SLOT_EVT        4

// register word offsets, from address bits 3 to 2
`define REG_CTRL        0
`define REG_CMP         1
`define REG_CNT         2

// fabric controller event positions
`define EVT_REF_POS     14
`define EVT_TIMER_BASE  17

`endif

// File: hw/soc_periph_pkg.sv
`default_nettype none

`include "soc_periph_defines.svh"

package soc_periph_pkg;

    // peripheral bus
    typedef logic [`APB_ADDR_W-1:0]  apb_addr_t;
    typedef logic [`APB_DATA_W-1:0]  apb_data_t;
    typedef logic [1:0]              reg_off_t;

    // event vector towards the fabric controller
    typedef logic [`FC_EVT_W-1:0]    fc_events_t;

    // timers
    typedef logic [`TIMER_CNT_W-1:0] timer_cnt_t;
    typedef logic [`N_TIMERS-1:0]    timer_vec_t;

endpackage

`default_nettype wire

// File: hw/periph_bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_defines.svh"

module periph_bus_decoder (
    input  logic                                      clk_i,
    input  logic                                      rst_i,
    input  soc_periph_pkg::apb_addr_t                 paddr_i,
    input  logic                                      psel_i,
    input  logic                                      penable_i,
    input  soc_periph_pkg::apb_data_t [`N_TIMERS-1:0] timer_rdata_i,
    input  soc_periph_pkg::apb_data_t                 evt_rdata_i,
    output soc_periph_pkg::timer_vec_t                timer_sel_o,
    output logic                                      evt_sel_o,
    output soc_periph_pkg::reg_off_t                  reg_off_o,
    output soc_periph_pkg::apb_data_t                 prdata_o,
    output logic                                      pready_o,
    output logic                                      pslverr_o
);

    logic [`SLOT_MSB-`SLOT_LSB:0] slot;
    logic                         unmapped;

    assign slot      = paddr_i[`SLOT_MSB:`SLOT_LSB];
    assign reg_off_o = paddr_i[3:2];
    assign unmapped  = (int'(slot) > `SLOT_EVT);

    ////////////////////////////////////////
    // slot selects
    ////////////////////////////////////////
    always_comb begin
        timer_sel_o = '0;
        for (int k = 0; k < `N_TIMERS; k++) begin
            timer_sel_o[k] = psel_i && (int'(slot) == k);
        end
    end

    assign evt_sel_o = psel_i && (int'(slot) == `SLOT_EVT);

    ////////////////////////////////////////
    // read data and error
    ////////////////////////////////////////
    // unmapped slots fall through to zero
    always_comb begin
        prdata_o = '0;
        for (int k = 0; k < `N_TIMERS; k++) begin
            if (int'(slot) == k) begin
                prdata_o = timer_rdata_i[k];
            end
        end
        if (int'(slot) == `SLOT_EVT) begin
            prdata_o = evt_rdata_i;
        end
    end

    // no wait states on this bus
    assign pready_o  = 1'b1;
    assign pslverr_o = psel_i && penable_i && unmapped;

    a_sel_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0({evt_sel_o, timer_sel_o}));

endmodule

`default_nettype wire

// File: hw/timer_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_defines.svh"

module timer_unit (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      sel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  soc_periph_pkg::reg_off_t  reg_off_i,
    input  soc_periph_pkg::apb_data_t pwdata_i,
    input  logic                      ref_tick_i,
    output soc_periph_pkg::apb_data_t rdata_o,
    output logic                      timer_evt_o
);

    logic                       wr_en;
    logic                       ctrl_en_q;
    logic                       ctrl_ref_q;
    soc_periph_pkg::timer_cnt_t cmp_q;
    soc_periph_pkg::timer_cnt_t cnt_q;
    logic                       tick;
    logic                       wrap;

    // write lands at the end of the access cycle
    assign wr_en = sel_i && penable_i && pwrite_i;

    // clock source counts every cycle, reference source on each edge strobe
    assign tick = ctrl_en_q && (ctrl_ref_q ? ref_tick_i : 1'b1);
    assign wrap = tick && (cnt_q == cmp_q);

    ////////////////////////////////////////
    // config registers
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ctrl_en_q  <= 1'b0;
            ctrl_ref_q <= 1'b0;
            cmp_q      <= '0;
        end else if (wr_en) begin
            if (reg_off_i == `REG_CTRL) begin
                ctrl_en_q  <= pwdata_i[0];
                ctrl_ref_q <= pwdata_i[1];
            end
            if (reg_off_i == `REG_CMP) begin
                cmp_q <= pwdata_i;
            end
        end
    end

    ////////////////////////////////////////
    // counter and event
    ////////////////////////////////////////
    // a software load of the count wins over the tick
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (wr_en && (reg_off_i == `REG_CNT)) begin
            cnt_q <= pwdata_i;
        end else if (wrap) begin
            cnt_q <= '0;
        end else if (tick) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            timer_evt_o <= 1'b0;
        end else begin
            timer_evt_o <= wrap;
        end
    end

    always_comb begin
        rdata_o = '0;
        case (reg_off_i)
            `REG_CTRL: rdata_o[1:0] = {ctrl_ref_q, ctrl_en_q};
            `REG_CMP:  rdata_o      = cmp_q;
            `REG_CNT:  rdata_o      = cnt_q;
            default:   rdata_o      = '0;
        endcase
    end

    a_no_evt_disabled: assert property (@(posedge clk_i) disable iff (rst_i)
        (ref_tick_i && !ctrl_en_q) |=> !timer_evt_o);

endmodule

`default_nettype wire

// File: hw/ref_clk_sync.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_defines.svh"

module ref_clk_sync (
    input  logic clk_i,
    input  logic rst_i,
    input  logic slow_clk_i,
    output logic ref_tick_o
);

    logic [1:0] sync_q;
    logic       dly_q;
    logic       tick_q;

    // two flops for the async input, then one more to compare against
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sync_q <= '0;
            dly_q  <= 1'b0;
            tick_q <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], slow_clk_i};
            dly_q  <= sync_q[1];
            // rise and fall both give one tick
            tick_q <= sync_q[1] ^ dly_q;
        end
    end

    assign ref_tick_o = tick_q;

    // the reference clock is far slower than clk_i
    a_tick_single: assert property (@(posedge clk_i) disable iff (rst_i)
        ref_tick_o |=> !ref_tick_o);

endmodule

`default_nettype wire

// File: hw/fc_event_map.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_defines.svh"

module fc_event_map (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        sel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  soc_periph_pkg::apb_data_t   pwdata_i,
    input  soc_periph_pkg::timer_vec_t  timer_evt_i,
    input  logic                        ref_tick_i,
    output soc_periph_pkg::apb_data_t   rdata_o,
    output soc_periph_pkg::fc_events_t  fc_events_o
);

    soc_periph_pkg::fc_events_t evt_vec;
    soc_periph_pkg::fc_events_t clr_mask;
    soc_periph_pkg::fc_events_t events_q;
    soc_periph_pkg::fc_events_t status_q;

    ////////////////////////////////////////
    // event placement
    ////////////////////////////////////////
    // fabric controller layout, every other bit stays low
    always_comb begin
        evt_vec = '0;
        evt_vec[`EVT_REF_POS] = ref_tick_i;
        for (int k = 0; k < `N_TIMERS; k++) begin
            evt_vec[`EVT_TIMER_BASE + k] = timer_evt_i[k];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            events_q <= '0;
        end else begin
            events_q <= evt_vec;
        end
    end

    assign fc_events_o = events_q;

    ////////////////////////////////////////
    // sticky status
    ////////////////////////////////////////
    // write ones to clear
    assign clr_mask = (sel_i && penable_i && pwrite_i) ? pwdata_i : '0;

    // a fresh event beats a clear of the same bit
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            status_q <= '0;
        end else begin
            status_q <= (status_q & ~clr_mask) | evt_vec;
        end
    end

    assign rdata_o = status_q;

endmodule

`default_nettype wire

// File: hw/soc_periph_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_defines.svh"

module soc_periph_top (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  soc_periph_pkg::apb_addr_t  paddr_i,
    input  logic                       psel_i,
    input  logic                       penable_i,
    input  logic                       pwrite_i,
    input  soc_periph_pkg::apb_data_t  pwdata_i,
    input  logic                       slow_clk_i,
    output soc_periph_pkg::apb_data_t  prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o,
    output soc_periph_pkg::fc_events_t fc_events_o
);

    soc_periph_pkg::timer_vec_t                timer_sel;
    logic                                      evt_sel;
    soc_periph_pkg::reg_off_t                  reg_off;
    soc_periph_pkg::apb_data_t [`N_TIMERS-1:0] timer_rdata;
    soc_periph_pkg::apb_data_t                 evt_rdata;
    soc_periph_pkg::timer_vec_t                timer_evt;
    logic                                      ref_tick;

    ////////////////////////////////////////
    // bus decode
    ////////////////////////////////////////
    periph_bus_decoder u_decoder (
        .clk_i         ( clk_i       ),
        .rst_i         ( rst_i       ),
        .paddr_i       ( paddr_i     ),
        .psel_i        ( psel_i      ),
        .penable_i     ( penable_i   ),
        .timer_rdata_i ( timer_rdata ),
        .evt_rdata_i   ( evt_rdata   ),
        .timer_sel_o   ( timer_sel   ),
        .evt_sel_o     ( evt_sel     ),
        .reg_off_o     ( reg_off     ),
        .prdata_o      ( prdata_o    ),
        .pready_o      ( pready_o    ),
        .pslverr_o     ( pslverr_o   )
    );

    // slow clock edges as core clock strobes
    ref_clk_sync u_ref_sync (
        .clk_i      ( clk_i      ),
        .rst_i      ( rst_i      ),
        .slow_clk_i ( slow_clk_i ),
        .ref_tick_o ( ref_tick   )
    );

    ////////////////////////////////////////
    // timers
    ////////////////////////////////////////
    for (genvar k = 0; k < `N_TIMERS; k++) begin : g_timer
        timer_unit u_timer (
            .clk_i       ( clk_i          ),
            .rst_i       ( rst_i          ),
            .sel_i       ( timer_sel[k]   ),
            .penable_i   ( penable_i      ),
            .pwrite_i    ( pwrite_i       ),
            .reg_off_i   ( reg_off        ),
            .pwdata_i    ( pwdata_i       ),
            .ref_tick_i  ( ref_tick       ),
            .rdata_o     ( timer_rdata[k] ),
            .timer_evt_o ( timer_evt[k]   )
        );
    end

    fc_event_map u_evt_map (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .sel_i       ( evt_sel     ),
        .penable_i   ( penable_i   ),
        .pwrite_i    ( pwrite_i    ),
        .pwdata_i    ( pwdata_i    ),
        .timer_evt_i ( timer_evt   ),
        .ref_tick_i  ( ref_tick    ),
        .rdata_o     ( evt_rdata   ),
        .fc_events_o ( fc_events_o )
    );

endmodule

`default_nettype wire

// File: bench/tb_soc_periph.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_periph_defines.svh"

module tb_soc_periph;

    localparam int CLK_PERIOD = 100;

    logic clk_i, rst_i, psel_i, penable_i, pwrite_i, slow_clk_i, pready_o, pslverr_o;
    soc_periph_pkg::apb_addr_t  paddr_i;
    soc_periph_pkg::apb_data_t  pwdata_i, prdata_o;
    soc_periph_pkg::fc_events_t fc_events_o;

    int errors, test_errs, tests_run, tests_failed, cyc, gap;
    int pulse_cnt[32], last_pulse[32], gap_min[32], gap_max[32];
    time last_wr_time;
    soc_periph_pkg::apb_data_t  shadow_cmp[`N_TIMERS];
    soc_periph_pkg::apb_data_t  shadow_cnt[`N_TIMERS];
    soc_periph_pkg::apb_data_t  shadow_ctrl[`N_TIMERS];
    soc_periph_pkg::fc_events_t model_status;

    soc_periph_top u_dut (.*);

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    ////////////////////////////////////////
    // event pulse monitor
    ////////////////////////////////////////
    always @(negedge clk_i) begin
        cyc++;
        for (int b = 0; b < 32; b++) begin
            if (!rst_i && fc_events_o[b]) begin
                if (pulse_cnt[b] > 0) begin
                    gap = cyc - last_pulse[b];
                    gap_min[b] = (gap < gap_min[b]) ? gap : gap_min[b];
                    gap_max[b] = (gap > gap_max[b]) ? gap : gap_max[b];
                end
                pulse_cnt[b]++;
                last_pulse[b] = cyc;
            end
        end
    end

    task automatic clear_counts();
        for (int b = 0; b < 32; b++) begin
            pulse_cnt[b] = 0;
            gap_min[b]   = 1 << 30;
            gap_max[b]   = 0;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
            test_errs++;
        end
    endtask

    function automatic soc_periph_pkg::apb_addr_t reg_addr(input int slot, input int off);
        return soc_periph_pkg::apb_addr_t'((slot << `SLOT_LSB) | (off << 2));
    endfunction

    ////////////////////////////////////////
    // bus transfers
    ////////////////////////////////////////
    task automatic bus_xfer(input logic wr, input soc_periph_pkg::apb_addr_t addr,
                            input soc_periph_pkg::apb_data_t wdata,
                            output soc_periph_pkg::apb_data_t rdata, output logic err);
        @(negedge clk_i);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(negedge clk_i);
        penable_i = 1'b1;
        #(CLK_PERIOD/4);
        // the access cycle has no wait states
        check_value("pready_o", {31'b0, pready_o}, 32'd1);
        rdata = prdata_o;
        err   = pslverr_o;
        // write lands on this edge
        @(posedge clk_i);
        last_wr_time = $time;
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic write_reg(input int slot, input int off, input soc_periph_pkg::apb_data_t data);
        soc_periph_pkg::apb_data_t rd;
        logic err;
        bus_xfer(1'b1, reg_addr(slot, off), data, rd, err);
        check_value("pslverr_o", {31'b0, err}, (slot > `SLOT_EVT) ? 32'd1 : 32'd0);
    endtask

    task automatic read_reg(input int slot, input int off, output soc_periph_pkg::apb_data_t data);
        logic err;
        bus_xfer(1'b0, reg_addr(slot, off), '0, data, err);
        check_value("pslverr_o", {31'b0, err}, (slot > `SLOT_EVT) ? 32'd1 : 32'd0);
    endtask

    task automatic check_timer_regs(input int t);
        soc_periph_pkg::apb_data_t rd;
        read_reg(t, `REG_CMP, rd);
        check_value("prdata_o", rd, shadow_cmp[t]);
        read_reg(t, `REG_CNT, rd);
        check_value("prdata_o", rd, shadow_cnt[t]);
        read_reg(t, `REG_CTRL, rd);
        check_value("prdata_o", rd, shadow_ctrl[t]);
    endtask

    // wait until the event vector has been quiet for 8 cycles
    task automatic settle();
        int quiet;
        int i;
        quiet = 0;
        for (i = 0; i < 64 && quiet < 8; i++) begin
            @(negedge clk_i);
            quiet = (fc_events_o == '0) ? quiet + 1 : 0;
        end
        if (quiet < 8) begin
            $display("timeout: event vector kept pulsing and did not settle");
            test_errs++;
        end
    endtask

    task automatic toggle_ref(input int edges);
        @(negedge clk_i);
        for (int k = 0; k < edges; k++) begin
            slow_clk_i = ~slow_clk_i;
            repeat (20 + $urandom % 41) @(negedge clk_i);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        errors += test_errs;
        if (test_errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: FAIL with %0d errors", name, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    initial begin
        soc_periph_pkg::apb_data_t rd;
        soc_periph_pkg::apb_data_t mask;
        int t, c, n, m, e, slot, exp_pulses;
        time t_en;
        void'($urandom(32'h627c));
        clk_i = 1'b0;
        rst_i = 1'b1;
        psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
        paddr_i = '0;
        pwdata_i = '0;
        slow_clk_i = 1'b0;
        model_status = '0;
        for (int k = 0; k < `N_TIMERS; k++) begin
            shadow_cmp[k]  = '0;
            shadow_cnt[k]  = '0;
            shadow_ctrl[k] = '0;
        end
        clear_counts();
        repeat (8) @(negedge clk_i);
        rst_i = 1'b0;

        // control values keep bit 0 clear so nothing counts yet
        for (int i = 0; i < 8; i++) begin
            t = $urandom % `N_TIMERS;
            shadow_cmp[t]  = $urandom;
            shadow_cnt[t]  = $urandom;
            shadow_ctrl[t] = ($urandom % 2) << 1;
            write_reg(t, `REG_CMP, shadow_cmp[t]);
            write_reg(t, `REG_CNT, shadow_cnt[t]);
            write_reg(t, `REG_CTRL, shadow_ctrl[t]);
            check_timer_regs(t);
        end
        finish_test("register readback");

        for (int i = 0; i < 6; i++) begin
            slot = `SLOT_EVT + 1 + $urandom % (15 - `SLOT_EVT);
            write_reg(slot, $urandom % 3, $urandom);
            read_reg(slot, $urandom % 3, rd);
            check_value("prdata_o", rd, '0);
        end
        for (int k = 0; k < `N_TIMERS; k++) begin
            check_timer_regs(k);
        end
        finish_test("unmapped slots");

        t = $urandom % `N_TIMERS;
        c = 2 + $urandom % 19;
        write_reg(t, `REG_CMP, c);
        write_reg(t, `REG_CNT, 0);
        clear_counts();
        write_reg(t, `REG_CTRL, 1);
        t_en = last_wr_time;
        repeat (40 + $urandom % 160) @(negedge clk_i);
        write_reg(t, `REG_CTRL, 0);
        // ticks fall on the edges after the enable edge, up to and including the disable edge
        n = int'((last_wr_time - t_en) / CLK_PERIOD);
        settle();
        exp_pulses = n / (c + 1);
        check_value($sformatf("fc_events_o[%0d] pulses", `EVT_TIMER_BASE + t),
                    pulse_cnt[`EVT_TIMER_BASE + t], exp_pulses);
        if (exp_pulses > 1) begin
            check_value("fc_events_o min spacing", gap_min[`EVT_TIMER_BASE + t], c + 1);
            check_value("fc_events_o max spacing", gap_max[`EVT_TIMER_BASE + t], c + 1);
        end
        if (exp_pulses > 0) begin
            model_status[`EVT_TIMER_BASE + t] = 1'b1;
        end
        finish_test("clock-sourced timer");

        clear_counts();
        m = 3 + $urandom % 6;
        toggle_ref(m);
        settle();
        check_value("fc_events_o[14] pulses", pulse_cnt[`EVT_REF_POS], m);
        model_status[`EVT_REF_POS] = 1'b1;
        finish_test("reference edges");

        t = $urandom % `N_TIMERS;
        c = 1 + $urandom % 4;
        e = 6 + $urandom % 12;
        write_reg(t, `REG_CMP, c);
        write_reg(t, `REG_CNT, 0);
        write_reg(t, `REG_CTRL, 3);
        clear_counts();
        toggle_ref(e);
        settle();
        write_reg(t, `REG_CTRL, 0);
        check_value($sformatf("fc_events_o[%0d] pulses", `EVT_TIMER_BASE + t),
                    pulse_cnt[`EVT_TIMER_BASE + t], e / (c + 1));
        check_value("fc_events_o[14] pulses", pulse_cnt[`EVT_REF_POS], e);
        read_reg(t, `REG_CNT, rd);
        check_value("prdata_o", rd, e % (c + 1));
        if (e / (c + 1) > 0) begin
            model_status[`EVT_TIMER_BASE + t] = 1'b1;
        end
        finish_test("reference-sourced timer");

        read_reg(`SLOT_EVT, 0, rd);
        check_value("prdata_o", rd, model_status);
        mask = $urandom & model_status;
        write_reg(`SLOT_EVT, 0, mask);
        model_status = model_status & ~mask;
        read_reg(`SLOT_EVT, 0, rd);
        check_value("prdata_o", rd, model_status);
        finish_test("sticky status");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * 20000);
        $display("timeout: simulation did not reach its end");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
hw/soc_periph_pkg.sv
hw/periph_bus_decoder.sv
hw/timer_unit.sv
hw/ref_clk_sync.sv
hw/fc_event_map.sv
hw/soc_periph_top.sv
bench/tb_soc_periph.sv

// File: Makefile
TOP := tb_soc_periph

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f verilog.f -Mdir obj_dir

# the simulator exit code is not trusted, the log decides
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
